// ==== source/msx_bus_pkg.sv ====
`default_nettype none

package msx_bus_pkg;

   // Primary slot number 0 to 3
   typedef logic [1:0] slot_t;

   // I/O port of the primary slot register
   localparam logic [7:0] PORT_SLOT  = 8'hA8;
   // I/O port of PPI port C (click, cassette motor)
   localparam logic [7:0] PORT_PPI_C = 8'hAA;

   // One CPU bus cycle, strobes already active high
   typedef struct packed {
      logic [15:0] addr;
      logic [7:0]  data_out;
      logic        mreq;
      logic        iorq;
      logic        rd;
      logic        wr;
      logic        m1;
      // One-cycle pulse at the start of a cycle
      logic        req;
   } cpu_bus_t;

   // Port A8h byte as raw value or as four page slots
   // Page 0 sits in the low two bits
   typedef union packed {
      logic [7:0]  raw;
      slot_t [3:0] pages;
   } slot_config_u;

endpackage

`default_nettype wire

// ==== source/msx_cfg_pkg.sv ====
`default_nettype none

package msx_cfg_pkg;

   // Static user settings
   typedef struct packed {
      // Extra wait states after each M1
      logic [2:0] wait_count;
      // Feed cassette input into the audio
      logic       tape_monitor;
   } msx_config_t;

   // Signed audio sample
   typedef logic signed [15:0] sample_t;

   // Key click level added to the mix
   localparam sample_t CLICK_LEVEL = 16'sh0400;
   // Cassette monitor level added to the mix
   localparam sample_t TAPE_LEVEL  = 16'sh0200;

endpackage

`default_nettype wire

// ==== source/slot_register.sv ====
`default_nettype none

module slot_register (
   input  logic                      clk,
   input  logic                      reset,
   input  msx_bus_pkg::cpu_bus_t     cpu,
   output msx_bus_pkg::slot_config_u slot_config,
   output logic                      keybeep,
   output logic                      tape_motor_on,
   output logic [7:0]                reg_data,
   output logic                      reg_oe
);
   import msx_bus_pkg::*;

   // PPI port C shadow
   logic [7:0] port_c;
   // Port decode on the low address byte
   logic       sel_slot;
   logic       sel_ppi_c;
   // I/O strobes
   logic       io_wr;
   logic       io_rd;

   assign sel_slot  = (cpu.addr[7:0] == PORT_SLOT);
   assign sel_ppi_c = (cpu.addr[7:0] == PORT_PPI_C);

   // Write taken only on the request strobe
   assign io_wr = cpu.req & cpu.iorq & cpu.wr;
   // Read is level based for the whole cycle
   assign io_rd = cpu.iorq & cpu.rd;

   always_ff @(posedge clk) begin
      if (reset) begin
         slot_config.raw <= 8'h00;
         // Bit 4 high keeps the motor stopped
         port_c          <= 8'h10;
      end else if (io_wr) begin
         if (sel_slot) begin
            slot_config.raw <= cpu.data_out;
         end
         if (sel_ppi_c) begin
            port_c <= cpu.data_out;
         end
      end
   end

   // Key click on bit 7
   assign keybeep       = port_c[7];
   // Motor runs while bit 4 is low
   assign tape_motor_on = ~port_c[4];

   // Read-back of both registers
   always_comb begin
      reg_oe   = 1'b0;
      reg_data = 8'hFF;
      if (io_rd && sel_slot) begin
         reg_oe   = 1'b1;
         reg_data = slot_config.raw;
      end else if (io_rd && sel_ppi_c) begin
         reg_oe   = 1'b1;
         reg_data = port_c;
      end
   end

   // One I/O write changes at most one register
   a_single_port_write : assert property (
      @(posedge clk) disable iff (reset)
      io_wr |=> ($stable(slot_config) || $stable(port_c))
   );

endmodule

`default_nettype wire

// ==== source/page_mapper.sv ====
`default_nettype none

module page_mapper #(
   parameter int RAM_ADDR_W = 27
) (
   input  msx_bus_pkg::cpu_bus_t     cpu,
   input  msx_bus_pkg::slot_config_u slot_config,
   input  logic [7:0]                reg_data,
   input  logic                      reg_oe,
   input  logic [7:0]                ram_dout,
   output logic [7:0]                d_to_cpu,
   output logic [RAM_ADDR_W-1:0]     ram_addr,
   output logic                      ram_ce,
   output logic                      ram_rnw,
   output logic [7:0]                ram_din
);
   import msx_bus_pkg::*;

   // 16 KB page from the top address bits
   logic [1:0] page;
   // Slot that the page is switched to
   slot_t      active_slot;
   // Memory read in progress
   logic       mem_rd;
   // Slot number stacked above the CPU address
   logic [17:0] flat_addr;

   assign page        = cpu.addr[15:14];
   assign active_slot = slot_config.pages[page];

   // Each slot gets its own 64 KB window
   assign flat_addr = {active_slot, cpu.addr};
   // Zero extension up to the RAM width
   assign ram_addr  = RAM_ADDR_W'(flat_addr);

   // Single RAM strobe for reads and writes
   assign ram_ce  = cpu.mreq & (cpu.rd | cpu.wr);
   // Read unless the CPU is writing
   assign ram_rnw = ~cpu.wr;
   assign ram_din = cpu.data_out;

   assign mem_rd = cpu.mreq & cpu.rd;

   // Register data wins over memory
   // Open bus reads as FFh
   always_comb begin
      if (reg_oe) begin
         d_to_cpu = reg_data;
      end else if (mem_rd) begin
         d_to_cpu = ram_dout;
      end else begin
         d_to_cpu = 8'hFF;
      end
   end

   // CPU never mixes memory and I/O requests
   // so RAM stays idle through any I/O cycle
   always_comb begin
      a_no_ram_in_io : assert (!(ram_ce && cpu.iorq))
         else $error("RAM strobe raised during an I/O cycle");
   end

endmodule

`default_nettype wire

// ==== source/wait_gen.sv ====
`default_nettype none

module wait_gen (
   input  logic       clk,
   input  logic       reset,
   input  logic       m1,
   input  logic       cpu_ce,
   input  logic       dev_wait,
   input  logic [2:0] wait_count,
   output logic       wait_n
);

   // Previous M1 level for edge detect
   logic       m1_q;
   // Remaining wait states
   logic [2:0] count;
   // New opcode fetch begins
   logic       m1_rise;

   assign m1_rise = m1 & ~m1_q;

   always_ff @(posedge clk) begin
      if (reset) begin
         m1_q  <= 1'b0;
         count <= 3'd0;
      end else begin
         m1_q <= m1;
         // Load wins over a coincident CPU clock
         if (m1_rise) begin
            count <= wait_count;
         end else if (cpu_ce && (count != 3'd0)) begin
            count <= count - 3'd1;
         end
      end
   end

   // Stall while counting or while a device asks
   assign wait_n = (count == 3'd0) && !dev_wait;

   // Count only rises on a fresh M1 load
   a_count_no_rise : assert property (
      @(posedge clk) disable iff (reset)
      !m1_rise |=> (count <= $past(count))
   );

endmodule

`default_nettype wire

// ==== source/audio_mix.sv ====
`default_nettype none

module audio_mix (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 keybeep,
   input  logic                 tape_motor_on,
   input  logic                 tape_in,
   input  logic                 tape_monitor,
   input  msx_cfg_pkg::sample_t device_sound,
   output msx_cfg_pkg::sample_t audio
);
   import msx_cfg_pkg::*;

   // Click plus cassette monitor
   sample_t            sys_sound;
   // One guard bit for overflow
   logic signed [16:0] sum;
   // Saturated result before the register
   sample_t            clipped;

   always_comb begin
      sys_sound = 16'sh0000;
      if (keybeep) begin
         sys_sound = sys_sound + CLICK_LEVEL;
      end
      // Tape heard only with the motor stopped
      if (tape_monitor && tape_in && !tape_motor_on) begin
         sys_sound = sys_sound + TAPE_LEVEL;
      end
   end

   // Sign-extended device sound plus the always positive system sound
   assign sum = {device_sound[15], device_sound} + {1'b0, sys_sound};

   // Clip when the guard bit disagrees with the sign
   always_comb begin
      case (sum[16:15])
         2'b01:   clipped = 16'sh7FFF;
         2'b10:   clipped = 16'sh8000;
         default: clipped = sum[15:0];
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         audio <= 16'sh0000;
      end else begin
         audio <= clipped;
      end
   end

   // System sound only ever adds to the device level
   a_never_below_device : assert property (
      @(posedge clk) disable iff (reset)
      1'b1 |=> (audio >= $past(device_sound))
   );

endmodule

`default_nettype wire

// ==== source/msx_bus_top.sv ====
`default_nettype none

module msx_bus_top #(
   parameter int RAM_ADDR_W = 27
) (
   input  logic                     clk,
   input  logic                     reset,
   input  msx_bus_pkg::cpu_bus_t    cpu,
   input  logic                     cpu_ce,
   input  logic                     dev_wait,
   input  msx_cfg_pkg::sample_t     device_sound,
   input  logic                     tape_in,
   input  msx_cfg_pkg::msx_config_t cfg,
   input  logic [7:0]               ram_dout,
   output logic [7:0]               d_to_cpu,
   output logic                     wait_n,
   output logic [RAM_ADDR_W-1:0]    ram_addr,
   output logic                     ram_ce,
   output logic                     ram_rnw,
   output logic [7:0]               ram_din,
   output logic                     tape_motor_on,
   output msx_cfg_pkg::sample_t     audio
);
   import msx_bus_pkg::*;

   // Primary slot byte from port A8h
   slot_config_u slot_config;
   // Key click bit from port C
   logic         keybeep;
   // Register read-back path
   logic [7:0]   reg_data;
   logic         reg_oe;

   // Ports A8h and AAh
   slot_register slot_register_inst (
      .clk           (clk),
      .reset         (reset),
      .cpu           (cpu),
      .slot_config   (slot_config),
      .keybeep       (keybeep),
      .tape_motor_on (tape_motor_on),
      .reg_data      (reg_data),
      .reg_oe        (reg_oe)
   );

   // Address map and read data
   page_mapper #(
      .RAM_ADDR_W (RAM_ADDR_W)
   ) page_mapper_inst (
      .cpu         (cpu),
      .slot_config (slot_config),
      .reg_data    (reg_data),
      .reg_oe      (reg_oe),
      .ram_dout    (ram_dout),
      .d_to_cpu    (d_to_cpu),
      .ram_addr    (ram_addr),
      .ram_ce      (ram_ce),
      .ram_rnw     (ram_rnw),
      .ram_din     (ram_din)
   );

   // M1 wait states
   wait_gen wait_gen_inst (
      .clk        (clk),
      .reset      (reset),
      .m1         (cpu.m1),
      .cpu_ce     (cpu_ce),
      .dev_wait   (dev_wait),
      .wait_count (cfg.wait_count),
      .wait_n     (wait_n)
   );

   // System sounds into the output mix
   audio_mix audio_mix_inst (
      .clk           (clk),
      .reset         (reset),
      .keybeep       (keybeep),
      .tape_motor_on (tape_motor_on),
      .tape_in       (tape_in),
      .tape_monitor  (cfg.tape_monitor),
      .device_sound  (device_sound),
      .audio         (audio)
   );

endmodule

`default_nettype wire

// ==== dv/clock_gen.sv ====
`default_nettype none

module clock_gen (
   output logic clk
);
   timeunit 1ns;
   timeprecision 1ps;

   initial begin
      clk = 1'b0;
   end

   // 100 ns period
   always #50 clk = ~clk;

endmodule

`default_nettype wire

// ==== dv/msx_bus_model.svh ====
`ifndef MSX_BUS_MODEL_SVH
`define MSX_BUS_MODEL_SVH

// Expected port A8h and port C contents
logic [7:0] model_slot;
logic [7:0] model_port_c;

task automatic model_reset();
   model_slot   = 8'h00;
   // Motor stopped out of reset
   model_port_c = 8'h10;
endtask

task automatic model_io_write(input logic [7:0] port, input logic [7:0] data);
   if (port == PORT_SLOT) model_slot = data;
   if (port == PORT_PPI_C) model_port_c = data;
endtask

// Unused ports read as open bus
function automatic logic [7:0] model_io_read(input logic [7:0] port);
   if (port == PORT_SLOT) return model_slot;
   if (port == PORT_PPI_C) return model_port_c;
   return 8'hFF;
endfunction

function automatic logic [RAM_ADDR_W-1:0] model_ram_addr(input logic [15:0] addr);
   logic [RAM_ADDR_W-1:0] flat;
   int                    page;
   page        = int'(addr[15:14]);
   flat        = '0;
   flat[15:0]  = addr;
   // Slot of this page goes right above the CPU address
   flat[17:16] = model_slot[2 * page +: 2];
   return flat;
endfunction

// Wait pulses expected for one M1
function automatic int model_wait_pulses(input logic [2:0] n);
   return int'(n);
endfunction

function automatic sample_t model_audio(input sample_t dev, input logic tape,
                                        input logic monitor);
   int level;
   level = int'(dev);
   // Key click
   if (model_port_c[7]) level += 1024;
   // Tape heard only while bit 4 holds the motor off
   if (monitor && tape && model_port_c[4]) level += 512;
   if (level > 32767) level = 32767;
   if (level < -32768) level = -32768;
   return sample_t'(level);
endfunction

`endif

// ==== dv/tb_msx_bus.sv ====
`default_nettype none

module tb_msx_bus;
   timeunit 1ns;
   timeprecision 1ps;

   import msx_bus_pkg::*;
   import msx_cfg_pkg::*;

   localparam int RAM_ADDR_W   = 27;
   // Inputs change this long after the rising edge
   localparam int DRIVE_DELAY  = 10;
   localparam int WAIT_TIMEOUT = 64;

   logic                  clk;
   logic                  reset;
   cpu_bus_t              cpu;
   logic                  cpu_ce;
   logic                  dev_wait;
   sample_t               device_sound;
   logic                  tape_in;
   msx_config_t           cfg;
   logic [7:0]            ram_dout;
   logic [7:0]            d_to_cpu;
   logic                  wait_n;
   logic [RAM_ADDR_W-1:0] ram_addr;
   logic                  ram_ce;
   logic                  ram_rnw;
   logic [7:0]            ram_din;
   logic                  tape_motor_on;
   sample_t               audio;

   integer seed     = 32'h6f90b677;
   int     errors   = 0;
   int     timeouts = 0;

   `include "msx_bus_model.svh"

   clock_gen clock_gen_inst (.clk(clk));

   msx_bus_top #(.RAM_ADDR_W(RAM_ADDR_W)) msx_bus_top_inst (
      .clk(clk), .reset(reset), .cpu(cpu), .cpu_ce(cpu_ce), .dev_wait(dev_wait),
      .device_sound(device_sound), .tape_in(tape_in), .cfg(cfg), .ram_dout(ram_dout),
      .d_to_cpu(d_to_cpu), .wait_n(wait_n), .ram_addr(ram_addr), .ram_ce(ram_ce),
      .ram_rnw(ram_rnw), .ram_din(ram_din), .tape_motor_on(tape_motor_on), .audio(audio)
   );

   function automatic logic [31:0] rand_word();
      return $random(seed);
   endfunction

   task automatic mismatch(input string what);
      errors++;
      $display("MISMATCH at %0t ns: %s", $time, what);
   endtask

   // Drive point of the next cycle
   task automatic next_cycle();
      @(posedge clk);
      #DRIVE_DELAY;
   endtask

   task automatic io_write(input logic [7:0] port, input logic [7:0] data);
      next_cycle();
      cpu          = '0;
      cpu.addr     = {8'(rand_word()), port};
      cpu.data_out = data;
      cpu.iorq     = 1'b1;
      cpu.wr       = 1'b1;
      cpu.req      = 1'b1;
      next_cycle();
      cpu.req = 1'b0;
      next_cycle();
      cpu = '0;
      model_io_write(port, data);
   endtask

   task automatic io_read_check(input logic [7:0] port);
      logic [7:0] expected;
      expected = model_io_read(port);
      next_cycle();
      cpu      = '0;
      cpu.addr = {8'(rand_word()), port};
      cpu.iorq = 1'b1;
      cpu.rd   = 1'b1;
      cpu.req  = 1'b1;
      // Memory data must not leak into an I/O read
      ram_dout = 8'(rand_word());
      #40;
      if (d_to_cpu !== expected)
         mismatch($sformatf("port %02h read %02h, expected %02h", port, d_to_cpu, expected));
      next_cycle();
      cpu = '0;
   endtask

   task automatic mem_cycle(input logic write);
      logic [RAM_ADDR_W-1:0] exp_addr;
      next_cycle();
      cpu          = '0;
      cpu.addr     = 16'(rand_word());
      cpu.data_out = 8'(rand_word());
      cpu.mreq     = 1'b1;
      cpu.rd       = ~write;
      cpu.wr       = write;
      cpu.req      = 1'b1;
      ram_dout     = 8'(rand_word());
      exp_addr     = model_ram_addr(cpu.addr);
      #40;
      if (ram_ce !== 1'b1) mismatch("ram_ce low during a memory cycle");
      if (ram_rnw !== ~write) mismatch("ram_rnw does not match the cycle type");
      if (ram_addr !== exp_addr)
         mismatch($sformatf("ram_addr %07h, expected %07h", ram_addr, exp_addr));
      if (write && ram_din !== cpu.data_out) mismatch("ram_din differs from CPU data");
      if (!write && d_to_cpu !== ram_dout) mismatch("d_to_cpu differs from ram_dout");
      next_cycle();
      cpu = '0;
   endtask

   // M1 fetch, then count CPU clocks until wait_n rises
   task automatic wait_check(input logic [2:0] n, input logic stall);
      logic [31:0] r;
      int          pulses;
      int          cycles;
      int          expected;
      pulses   = 0;
      cycles   = 0;
      // Device stall outlasts the count by two pulses
      expected = stall ? model_wait_pulses(n) + 2 : model_wait_pulses(n);
      cfg.wait_count = n;
      dev_wait       = stall;
      next_cycle();
      cpu      = '0;
      cpu.addr = 16'(rand_word());
      cpu.mreq = 1'b1;
      cpu.rd   = 1'b1;
      cpu.m1   = 1'b1;
      cpu.req  = 1'b1;
      next_cycle();
      cpu.req = 1'b0;
      while (!wait_n && cycles < WAIT_TIMEOUT) begin
         if (dev_wait && pulses >= expected) begin
            dev_wait = 1'b0;
         end else begin
            // Random gaps between CPU clocks
            r      = rand_word();
            cpu_ce = r[0];
            if (cpu_ce) pulses++;
         end
         next_cycle();
         cpu_ce = 1'b0;
         cycles++;
      end
      if (cycles >= WAIT_TIMEOUT) begin
         timeouts++;
         $display("Timeout: wait_n still low %0d cycles after the M1 cycle", cycles);
      end else if (pulses != expected) begin
         mismatch($sformatf("wait_n low for %0d pulses, expected %0d", pulses, expected));
      end
      cpu      = '0;
      dev_wait = 1'b0;
   endtask

   task automatic audio_check(input sample_t dev);
      logic [31:0] r;
      sample_t     expected;
      r = rand_word();
      // Port C with random click and motor bits
      io_write(PORT_PPI_C, {r[0], 2'b00, r[1], 4'h0});
      next_cycle();
      device_sound     = dev;
      tape_in          = r[2];
      cfg.tape_monitor = r[3];
      expected         = model_audio(dev, r[2], r[3]);
      next_cycle();
      if (audio !== expected)
         mismatch($sformatf("audio %04h for device %04h, expected %04h", audio, dev, expected));
   endtask

   initial begin
      logic [31:0] r;
      cpu          = '0;
      cpu_ce       = 1'b0;
      dev_wait     = 1'b0;
      device_sound = '0;
      tape_in      = 1'b0;
      cfg          = '0;
      ram_dout     = 8'h00;
      reset        = 1'b1;
      model_reset();
      repeat (16) @(posedge clk);
      #DRIVE_DELAY;
      reset = 1'b0;

      // Idle bus straight after reset
      next_cycle();
      #40;
      if (d_to_cpu !== 8'hFF) mismatch("idle d_to_cpu is not FF");
      if (ram_ce !== 1'b0) mismatch("ram_ce high on an idle bus");
      if (wait_n !== 1'b1) mismatch("wait_n low after reset");
      if (tape_motor_on !== 1'b0) mismatch("tape motor on after reset");
      if (audio !== 16'sh0000) mismatch("audio not zero after reset");
      io_read_check(PORT_SLOT);

      // Register writes and read-back
      repeat (40) begin
         r = rand_word();
         io_write(r[8] ? PORT_SLOT : PORT_PPI_C, r[7:0]);
         io_read_check(PORT_SLOT);
         io_read_check(PORT_PPI_C);
         if (tape_motor_on !== ~model_port_c[4]) mismatch("tape_motor_on wrong");
      end

      // Mixed memory cycles, slot changes and stray port reads
      repeat (200) begin
         r = rand_word();
         if (r[3:0] == 4'h0) io_write(PORT_SLOT, r[15:8]);
         else if (r[3:0] == 4'h1) io_read_check(r[23:16]);
         else mem_cycle(r[4]);
      end

      // Wait states, then device stall on top
      repeat (12) begin
         r = rand_word();
         wait_check(r[2:0], 1'b0);
      end
      repeat (4) begin
         r = rand_word();
         wait_check(r[2:0], 1'b1);
      end

      // Audio over the full range then near both limits
      repeat (60) begin
         r = rand_word();
         audio_check(sample_t'(r[15:0]));
      end
      repeat (20) begin
         r = rand_word();
         audio_check(sample_t'(16'h7C00 + {5'h00, r[10:0]}));
         audio_check(sample_t'(16'h8000 + {5'h00, r[26:16]}));
      end

      $display("Mismatches: %0d, timeouts: %0d", errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+dv
source/msx_bus_pkg.sv
source/msx_cfg_pkg.sv
source/slot_register.sv
source/page_mapper.sv
source/wait_gen.sv
source/audio_mix.sv
source/msx_bus_top.sv
dv/clock_gen.sv
dv/tb_msx_bus.sv

// ==== Makefile ====
SRCS := $(wildcard source/*.sv dv/*.sv dv/*.svh)

.PHONY: run clean

obj_dir/Vtb_msx_bus: $(SRCS) src.f
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f src.f --top-module tb_msx_bus

run: obj_dir/Vtb_msx_bus
	@out="$$(./obj_dir/Vtb_msx_bus)"; \
	echo "$$out"; \
	echo "$$out" | grep -q '^All tests passed$$'

clean:
	rm -rf obj_dir
